// File: flist.f
rtl/ctrl_pkg.sv
rtl/ctrl_counter.sv
rtl/flush_ctrl.sv
rtl/fence_t_seq.sv
rtl/ctrl_top.sv
verification/tb_ctrl_top.sv

// File: rtl/ctrl_counter.sv
`timescale 1ns/1ps

module ctrl_counter #(
  parameter int unsigned Width = 4
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             clear_i,
  input  logic             en_i,
  input  logic             load_i,
  input  logic             down_i,
  input  logic [Width-1:0] d_i,
  output logic [Width-1:0] q_o
);

  logic [Width-1:0] cnt_d, cnt_q;

  // ------------------------------------------------------------
  // Next count
  // ------------------------------------------------------------
  // Clear wins over load, load wins over counting
  always_comb begin
    cnt_d = cnt_q;
    if (clear_i) begin
      cnt_d = '0;
    end else if (load_i) begin
      cnt_d = d_i;
    end else if (en_i) begin
      // Wraps in both directions, callers gate en_i at the ends
      cnt_d = down_i ? cnt_q - Width'(1) : cnt_q + Width'(1);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  assign q_o = cnt_q;

  // Owners never clear and load in the same cycle
  a_clear_load_excl : assert property (
    @(posedge clk_i) disable iff (!rst_ni) !(clear_i && load_i)
  );

endmodule

// File: rtl/ctrl_pkg.sv
package ctrl_pkg;

  // ------------------------------------------------------------
  // Fixed fence.t timing
  // ------------------------------------------------------------
  // Idle cycles the cache must show before the pad phase
  localparam int unsigned DRAIN_IDLE_CYCLES = 16;
  // Length of the microarchitectural reset pulse
  localparam int unsigned RST_UARCH_CYCLES  = 16;
  // Extra cycles of cache-init suppression after the reset pulse
  localparam int unsigned CACHE_INIT_HOLD   = 3;

  // ------------------------------------------------------------
  // Request and command bundles
  // ------------------------------------------------------------
  // Single-cycle request strobes from the core
  typedef struct packed {
    logic mispredict;
    logic fence;
    logic fence_i;
    logic sfence_vma;
    logic hfence_vvma;
    logic hfence_gvma;
    logic flush_csr;
    logic exception;
    logic eret;
    logic debug;
  } flush_req_t;

  // Per-stage flush strobes and the commit-PC redirect
  typedef struct packed {
    logic set_pc_commit;
    logic flush_if;
    logic flush_unissued;
    logic flush_id;
    logic flush_ex;
    logic flush_bp;
    logic flush_icache;
    logic flush_tlb;
    logic flush_tlb_vvma;
    logic flush_tlb_gvma;
  } flush_cmd_t;

  // fence.t sequencer states
  typedef enum logic [2:0] {
    IDLE,
    FLUSH_DCACHE,
    DRAIN_REQS,
    PAD,
    RST_UARCH
  } fence_t_state_e;

  // RISC-V privilege encoding
  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_S = 2'b01,
    PRIV_M = 2'b11
  } priv_lvl_e;

endpackage

// File: rtl/ctrl_top.sv
`timescale 1ns/1ps

module ctrl_top #(
  parameter int unsigned Vlen     = 32,
  parameter bit          DcacheWb = 1'b1,
  parameter bit          HypEn    = 1'b1
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  ctrl_pkg::flush_req_t req_i,
  input  logic                 v_i,
  input  logic                 fence_t_i,
  input  logic [Vlen-1:0]      pc_commit_i,
  input  logic [Vlen-1:0]      boot_addr_i,
  input  logic                 flush_dcache_ack_i,
  input  logic                 cache_busy_i,
  input  logic                 halt_csr_i,
  input  logic [31:0]          fence_t_pad_i,
  input  logic                 fence_t_src_sel_i,
  input  logic                 time_irq_i,
  input  ctrl_pkg::priv_lvl_e  priv_lvl_i,
  output ctrl_pkg::flush_cmd_t cmd_o,
  output logic                 flush_dcache_o,
  output logic [Vlen-1:0]      rst_addr_o,
  output logic                 halt_o,
  output logic                 stall_cache_o,
  output logic                 rst_uarch_no,
  output logic                 cache_init_no,
  output logic [31:0]          fence_t_ceil_o
);

  // Halt sources from the two blocks
  logic fence_active;
  logic seq_busy;

  // ------------------------------------------------------------
  // Request decode and dcache fence
  // ------------------------------------------------------------
  flush_ctrl #(
    .Vlen     (Vlen),
    .DcacheWb (DcacheWb),
    .HypEn    (HypEn)
  ) flush_ctrl_i (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .req_i              (req_i),
    .v_i                (v_i),
    .fence_t_i          (fence_t_i),
    .pc_commit_i        (pc_commit_i),
    .boot_addr_i        (boot_addr_i),
    .flush_dcache_ack_i (flush_dcache_ack_i),
    .cmd_o              (cmd_o),
    .flush_dcache_o     (flush_dcache_o),
    .fence_active_o     (fence_active),
    .rst_addr_o         (rst_addr_o)
  );

  // ------------------------------------------------------------
  // fence.t microreset sequencer
  // ------------------------------------------------------------
  fence_t_seq fence_t_seq_i (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .fence_t_i          (fence_t_i),
    .flush_dcache_ack_i (flush_dcache_ack_i),
    .cache_busy_i       (cache_busy_i),
    .fence_t_pad_i      (fence_t_pad_i),
    .fence_t_src_sel_i  (fence_t_src_sel_i),
    .time_irq_i         (time_irq_i),
    .priv_lvl_i         (priv_lvl_i),
    .seq_busy_o         (seq_busy),
    .stall_cache_o      (stall_cache_o),
    .rst_uarch_no       (rst_uarch_no),
    .cache_init_no      (cache_init_no),
    .fence_t_ceil_o     (fence_t_ceil_o)
  );

  // Commit stalls on WFI, a pending dcache fence or a running fence.t
  assign halt_o = halt_csr_i | fence_active | seq_busy;

endmodule

// File: rtl/fence_t_seq.sv
`timescale 1ns/1ps

module fence_t_seq (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                fence_t_i,
  input  logic                flush_dcache_ack_i,
  input  logic                cache_busy_i,
  input  logic [31:0]         fence_t_pad_i,
  input  logic                fence_t_src_sel_i,
  input  logic                time_irq_i,
  input  ctrl_pkg::priv_lvl_e priv_lvl_i,
  output logic                seq_busy_o,
  output logic                stall_cache_o,
  output logic                rst_uarch_no,
  output logic                cache_init_no,
  output logic [31:0]         fence_t_ceil_o
);

  import ctrl_pkg::*;

  localparam int unsigned DrainW = $clog2(DRAIN_IDLE_CYCLES);
  localparam int unsigned RstW   = $clog2(RST_UARCH_CYCLES);

  fence_t_state_e state_d, state_q;
  logic [RstW-1:0] rst_cnt_d, rst_cnt_q;

  logic [DrainW-1:0] drain_cnt;
  logic [31:0]       pad_cnt;
  logic              drain_done;
  logic              in_rst;

  // Pad start sources
  logic      time_irq_q;
  priv_lvl_e priv_lvl_q;
  logic      irq_edge, user_exit, load_pad;

  // Cache-init suppression tail
  logic [CACHE_INIT_HOLD-1:0] init_hold_q;

  // ------------------------------------------------------------
  // Counters
  // ------------------------------------------------------------
  // Idle streak of the cache, any busy cycle restarts it
  ctrl_counter #(
    .Width (DrainW)
  ) drain_cnt_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .clear_i (cache_busy_i),
    .en_i    (drain_cnt != DrainW'(DRAIN_IDLE_CYCLES - 1)),
    .load_i  (1'b0),
    .down_i  (1'b0),
    .d_i     ('0),
    .q_o     (drain_cnt)
  );

  // Timer irq edge or leaving U-mode, selected by the CSR bit
  assign irq_edge  = time_irq_i & ~time_irq_q;
  assign user_exit = (priv_lvl_q == PRIV_U) && (priv_lvl_i != PRIV_U);
  assign load_pad  = fence_t_src_sel_i ? user_exit : irq_edge;

  // Pad runs down to zero and parks there
  ctrl_counter #(
    .Width (32)
  ) pad_cnt_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .clear_i (1'b0),
    .en_i    (|pad_cnt),
    .load_i  (load_pad),
    .down_i  (1'b1),
    .d_i     (fence_t_pad_i),
    .q_o     (pad_cnt)
  );

  // Sixteenth idle cycle in a row
  assign drain_done = (drain_cnt == DrainW'(DRAIN_IDLE_CYCLES - 1)) && !cache_busy_i;

  // ------------------------------------------------------------
  // fence.t FSM
  // ------------------------------------------------------------
  always_comb begin
    state_d        = state_q;
    rst_cnt_d      = rst_cnt_q;
    fence_t_ceil_o = '0;

    unique case (state_q)
      IDLE: begin
        if (fence_t_i) state_d = FLUSH_DCACHE;
      end
      // Wait for the dcache writeback to finish
      FLUSH_DCACHE: begin
        if (flush_dcache_ack_i) state_d = DRAIN_REQS;
      end
      // Let outstanding bus handshakes complete
      DRAIN_REQS: begin
        if (drain_done) begin
          state_d = PAD;
          // Time already spent since the pad start
          fence_t_ceil_o = (pad_cnt == '0) ? '0 : fence_t_pad_i - pad_cnt;
        end
      end
      PAD: begin
        if (pad_cnt == '0) state_d = RST_UARCH;
      end
      // Fixed-length microreset
      RST_UARCH: begin
        if (rst_cnt_q == RstW'(RST_UARCH_CYCLES - 1)) begin
          rst_cnt_d = '0;
          state_d   = IDLE;
        end else begin
          rst_cnt_d = rst_cnt_q + RstW'(1);
        end
      end
      default: state_d = IDLE;
    endcase
  end

  assign in_rst        = (state_q == RST_UARCH);
  assign rst_uarch_no  = !in_rst;
  // Hold cache init off during reset and a few cycles beyond
  assign cache_init_no = in_rst | (|init_hold_q);
  assign seq_busy_o    = (state_q != IDLE);
  assign stall_cache_o = (state_q != IDLE);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= IDLE;
      rst_cnt_q   <= '0;
      time_irq_q  <= 1'b0;
      priv_lvl_q  <= PRIV_M;
      init_hold_q <= '0;
    end else begin
      state_q     <= state_d;
      rst_cnt_q   <= rst_cnt_d;
      time_irq_q  <= time_irq_i;
      priv_lvl_q  <= priv_lvl_i;
      init_hold_q <= {init_hold_q[CACHE_INIT_HOLD-2:0], in_rst};
    end
  end

  // Microreset pulse is exactly RST_UARCH_CYCLES long
  a_rst_len : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
      $rose(rst_uarch_no) |-> $past(!rst_uarch_no, RST_UARCH_CYCLES)
                              && $past(rst_uarch_no, RST_UARCH_CYCLES + 1)
  );

endmodule

// File: rtl/flush_ctrl.sv
`timescale 1ns/1ps

module flush_ctrl #(
  parameter int unsigned Vlen     = 32,
  parameter bit          DcacheWb = 1'b1,
  parameter bit          HypEn    = 1'b1
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  ctrl_pkg::flush_req_t req_i,
  input  logic                 v_i,
  input  logic                 fence_t_i,
  input  logic [Vlen-1:0]      pc_commit_i,
  input  logic [Vlen-1:0]      boot_addr_i,
  input  logic                 flush_dcache_ack_i,
  output ctrl_pkg::flush_cmd_t cmd_o,
  output logic                 flush_dcache_o,
  output logic                 fence_active_o,
  output logic [Vlen-1:0]      rst_addr_o
);

  import ctrl_pkg::*;

  // Hypervisor fences only exist with the H extension
  logic hfence_v, hfence_g;
  // Anything that redirects to the commit PC and empties the pipe
  logic side_effect;
  // Trap-like redirects take their own PC
  logic trap;
  // New dcache flush request this cycle
  logic dcache_req;

  logic            fence_active_d, fence_active_q;
  logic            flush_dcache_d;
  logic [Vlen-1:0] rst_addr_d, rst_addr_q;

  assign hfence_v    = HypEn && req_i.hfence_vvma;
  assign hfence_g    = HypEn && req_i.hfence_gvma;
  assign side_effect = req_i.fence | req_i.fence_i | req_i.sfence_vma
                     | hfence_v | hfence_g | req_i.flush_csr;
  assign trap        = req_i.exception | req_i.eret | req_i.debug;

  // ------------------------------------------------------------
  // Request decode
  // ------------------------------------------------------------
  always_comb begin
    cmd_o = '0;

    // Mispredict only drops the front end
    if (req_i.mispredict) begin
      cmd_o.flush_if       = 1'b1;
      cmd_o.flush_unissued = 1'b1;
    end

    // Fences and CSR side effects restart from the commit PC
    if (side_effect) begin
      cmd_o.set_pc_commit  = 1'b1;
      cmd_o.flush_if       = 1'b1;
      cmd_o.flush_unissued = 1'b1;
      cmd_o.flush_id       = 1'b1;
      cmd_o.flush_ex       = 1'b1;
    end

    // Instruction memory changed, fence.t also wipes the icache
    if (req_i.fence_i || fence_t_i) begin
      cmd_o.flush_icache = 1'b1;
    end

    // sfence.vma in virtual mode targets the guest TLB
    if (req_i.sfence_vma) begin
      if (HypEn && v_i) cmd_o.flush_tlb_vvma = 1'b1;
      else              cmd_o.flush_tlb      = 1'b1;
    end
    if (hfence_v) cmd_o.flush_tlb_vvma = 1'b1;
    if (hfence_g) cmd_o.flush_tlb_gvma = 1'b1;

    // Trap entry overrides the commit redirect, also clears predictors
    if (trap) begin
      cmd_o.set_pc_commit  = 1'b0;
      cmd_o.flush_if       = 1'b1;
      cmd_o.flush_unissued = 1'b1;
      cmd_o.flush_id       = 1'b1;
      cmd_o.flush_ex       = 1'b1;
      cmd_o.flush_bp       = 1'b1;
    end
  end

  // ------------------------------------------------------------
  // Dcache fence tracking
  // ------------------------------------------------------------
  // Write-through caches need no flush on fence or fence.i
  assign dcache_req = (DcacheWb && (req_i.fence || req_i.fence_i)) || fence_t_i;

  always_comb begin
    fence_active_d = fence_active_q;
    flush_dcache_d = 1'b0;
    rst_addr_d     = rst_addr_q;

    // Hold the flush request until the cache acknowledges
    if (fence_active_q) begin
      if (flush_dcache_ack_i) fence_active_d = 1'b0;
      else                    flush_dcache_d = 1'b1;
    end

    if (dcache_req) begin
      fence_active_d = 1'b1;
      flush_dcache_d = 1'b1;
    end

    // Resume after the fence.t instruction once out of microreset
    if (fence_t_i) begin
      rst_addr_d = pc_commit_i + Vlen'(4);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fence_active_q <= 1'b0;
      flush_dcache_o <= 1'b0;
      rst_addr_q     <= boot_addr_i;
    end else begin
      fence_active_q <= fence_active_d;
      // Registered, the cache side sees a clean strobe
      flush_dcache_o <= flush_dcache_d;
      rst_addr_q     <= rst_addr_d;
    end
  end

  assign fence_active_o = fence_active_q;
  assign rst_addr_o     = rst_addr_q;

  // Cache never sees a flush without the halt that guards it
  a_flush_in_fence : assert property (
    @(posedge clk_i) disable iff (!rst_ni) flush_dcache_o |-> fence_active_q
  );

endmodule

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f flist.f --top-module tb_ctrl_top -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TESTBENCH PASSED" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// File: verification/ctrl_golden.txt
# Opcodes: REQ mask(hex) v(hex) cmd(hex) | FENCE kind(0 fence, 1 fence.i) ack_delay
# FENCE_T pc(hex) pad(dec) irq_timing(0 early, 1 at fence) src_sel | RESET_CHECK
RESET_CHECK
REQ 000 0 000
REQ 200 0 180
REQ 008 0 3e0
REQ 040 0 3e4
REQ 040 1 3e2
REQ 020 0 3e2
REQ 010 0 3e1
REQ 004 0 1f0
REQ 002 0 1f0
REQ 001 0 1f0
REQ 00a 0 1f0
REQ 041 0 1f4
REQ 208 0 3e0
REQ 244 1 1f2
FENCE 0 0
FENCE 1 4
FENCE 0 2
FENCE_T 00002000 20 0 0
FENCE_T 00003ffc 60 1 0
FENCE_T 00004010 60 1 1
FENCE_T 00005000 20 0 1
RESET_CHECK

// File: verification/tb_ctrl_top.sv
`timescale 1ns/1ps

module tb_ctrl_top;

  import ctrl_pkg::*;

  localparam int unsigned Vlen = 32;
  localparam logic [31:0] BootAddr = 32'h0000_1000;

  // DUT ports
  logic            clk_i;
  logic            rst_ni;
  flush_req_t      req_i;
  logic            v_i;
  logic            fence_t_i;
  logic [Vlen-1:0] pc_commit_i;
  logic [Vlen-1:0] boot_addr_i;
  logic            flush_dcache_ack_i;
  logic            cache_busy_i;
  logic            halt_csr_i;
  logic [31:0]     fence_t_pad_i;
  logic            fence_t_src_sel_i;
  logic            time_irq_i;
  priv_lvl_e       priv_lvl_i;
  flush_cmd_t      cmd_o;
  logic            flush_dcache_o;
  logic [Vlen-1:0] rst_addr_o;
  logic            halt_o;
  logic            stall_cache_o;
  logic            rst_uarch_no;
  logic            cache_init_no;
  logic [31:0]     fence_t_ceil_o;

  // Bookkeeping
  int          cyc = 0;
  int          ack_delay = 0;
  int          n_lines = 0;
  logic [31:0] lfsr = 32'hf28a;

  ctrl_top #(.Vlen(Vlen)) dut_i (.*);

  always #5 clk_i = ~clk_i;

  // Cycle index, read after the edge
  always @(posedge clk_i) cyc <= cyc + 1;

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------
  // Fibonacci LFSR, taps 32 22 2 1, one new bit per call
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp);
    if (act !== exp) begin
      stop_run($sformatf("ERROR time=%0t %s expected=%0h actual=%0h", $time, name, exp, act));
    end
  endtask

  task automatic apply_reset();
    @(posedge clk_i);
    #1 rst_ni = 1'b0;
    repeat (8) @(posedge clk_i);
    #1 rst_ni = 1'b1;
  endtask

  // Reset values of every output
  task automatic check_reset_values();
    @(negedge clk_i);
    check("cmd_o", 32'(cmd_o), 32'h0);
    check("flush_dcache_o", 32'(flush_dcache_o), 32'h0);
    check("stall_cache_o", 32'(stall_cache_o), 32'h0);
    check("rst_uarch_no", 32'(rst_uarch_no), 32'h1);
    check("cache_init_no", 32'(cache_init_no), 32'h0);
    check("halt_o", 32'(halt_o), 32'h0);
    check("rst_addr_o", rst_addr_o, boot_addr_i);
  endtask

  // WFI halt from the CSR file reaches halt_o on its own
  task automatic probe_wfi_halt();
    @(posedge clk_i);
    #1 halt_csr_i = 1'b1;
    @(negedge clk_i);
    check("halt_o", 32'(halt_o), 32'h1);
    @(posedge clk_i);
    #1 halt_csr_i = 1'b0;
    @(negedge clk_i);
    check("halt_o", 32'(halt_o), 32'h0);
  endtask

  // Single request strobe, cmd_o checked in the same cycle
  task automatic do_req(input logic [31:0] mask, input logic [31:0] v, input logic [31:0] exp);
    @(posedge clk_i);
    #1;
    req_i = flush_req_t'(mask[9:0]);
    v_i   = v[0];
    @(negedge clk_i);
    check("cmd_o", 32'(cmd_o), exp);
    @(posedge clk_i);
    #1;
    req_i = '0;
    v_i   = 1'b0;
  endtask

  // fence or fence.i, flush strobe held until the cycle after the ack
  task automatic do_fence(input logic [31:0] kind, input logic [31:0] delay);
    int high;
    ack_delay = delay;
    @(posedge clk_i);
    #1;
    if (kind == 0) req_i.fence = 1'b1;
    else           req_i.fence_i = 1'b1;
    @(negedge clk_i);
    check("flush_dcache_o", 32'(flush_dcache_o), 32'h0);
    @(posedge clk_i);
    #1 req_i = '0;
    high = 0;
    @(negedge clk_i);
    while (flush_dcache_o) begin
      check("halt_o", 32'(halt_o), 32'h1);
      high++;
      @(negedge clk_i);
    end
    check("flush_dcache_o high cycles", high, delay + 1);
    check("halt_o", 32'(halt_o), 32'h0);
  endtask

  // Pad start event on the selected source
  task automatic start_pad(input logic [31:0] src);
    if (src[0]) priv_lvl_i = PRIV_M;
    else        time_irq_i = 1'b1;
  endtask

  task automatic do_fence_t(input logic [31:0] pc, input logic [31:0] pad,
                            input logic [31:0] timing, input logic [31:0] src);
    int          load_cyc;
    int          last_busy;
    int          rst_start;
    int          low_cnt;
    int          init_cnt;
    logic [31:0] ceil_seen;
    ack_delay = 3;
    last_busy = 0;
    ceil_seen = '0;
    @(posedge clk_i);
    #1;
    fence_t_pad_i     = pad;
    fence_t_src_sel_i = src[0];
    // Run in user mode so that a later drop to M can start the pad
    if (src[0]) begin
      @(posedge clk_i);
      #1 priv_lvl_i = PRIV_U;
    end
    // Early start, pad runs out before the fence
    if (timing == 0) begin
      @(posedge clk_i);
      #1 start_pad(src);
      @(posedge clk_i);
      #1 time_irq_i = 1'b0;
      repeat (pad + 4) @(posedge clk_i);
    end
    @(posedge clk_i);
    #1;
    fence_t_i   = 1'b1;
    pc_commit_i = pc;
    if (timing != 0) begin
      start_pad(src);
    end else if (src[0]) begin
      // Timer edge on the unselected source must not restart the pad
      time_irq_i = 1'b1;
    end
    load_cyc = cyc;
    // fence.t also wipes the icache
    @(negedge clk_i);
    check("cmd_o.flush_icache", 32'(cmd_o.flush_icache), 32'h1);
    @(posedge clk_i);
    #1;
    fence_t_i    = 1'b0;
    time_irq_i   = 1'b0;
    // Cache busy with the writeback, so the idle streak starts inside the drain
    cache_busy_i = 1'b1;
    @(negedge clk_i);
    check("rst_addr_o", rst_addr_o, pc + 32'd4);
    // Dcache flush, answered by the cache model
    while (flush_dcache_o) @(negedge clk_i);
    // Drain window, first cycle always busy
    for (int i = 0; i < 10; i++) begin
      @(posedge clk_i);
      #1;
      lfsr = lfsr_step(lfsr);
      cache_busy_i = (i == 0) ? 1'b1 : lfsr[0];
      if (cache_busy_i) last_busy = cyc;
      @(negedge clk_i);
      check("stall_cache_o", 32'(stall_cache_o), 32'h1);
    end
    @(posedge clk_i);
    #1 cache_busy_i = 1'b0;
    @(negedge clk_i);
    while (rst_uarch_no) begin
      check("stall_cache_o", 32'(stall_cache_o), 32'h1);
      check("halt_o", 32'(halt_o), 32'h1);
      if (fence_t_ceil_o != 0) ceil_seen = fence_t_ceil_o;
      @(negedge clk_i);
    end
    rst_start = cyc;
    low_cnt   = 0;
    init_cnt  = 0;
    while (!rst_uarch_no) begin
      check("stall_cache_o", 32'(stall_cache_o), 32'h1);
      check("cache_init_no", 32'(cache_init_no), 32'h1);
      low_cnt++;
      @(negedge clk_i);
    end
    check("rst_uarch_no low cycles", low_cnt, 32'd16);
    check("stall_cache_o", 32'(stall_cache_o), 32'h0);
    while (cache_init_no) begin
      init_cnt++;
      @(negedge clk_i);
    end
    check("cache_init_no high cycles", low_cnt + init_cnt, 32'd19);
    if (rst_start - last_busy < 16) begin
      stop_run("Microreset began before the cache was idle for 16 cycles");
    end
    if (timing == 0) begin
      check("fence_t_ceil_o", ceil_seen, 32'h0);
    end else begin
      if (ceil_seen == 0 || ceil_seen > pad) begin
        stop_run($sformatf("Ceiling %0d is not within 1 to pad %0d", ceil_seen, pad));
      end
      if (rst_start - load_cyc < pad) begin
        stop_run("Microreset began before the pad ran out");
      end
    end
    @(posedge clk_i);
    #1 fence_t_src_sel_i = 1'b0;
  endtask

  // ------------------------------------------------------------
  // Cache model
  // ------------------------------------------------------------
  initial begin
    flush_dcache_ack_i = 1'b0;
    forever begin
      @(posedge clk_i);
      #1;
      if (flush_dcache_o) begin
        repeat (ack_delay) @(posedge clk_i);
        #1 flush_dcache_ack_i = 1'b1;
        @(posedge clk_i);
        #1 flush_dcache_ack_i = 1'b0;
      end
    end
  end

  // Watchdog, budget scales with the golden file
  initial begin
    wait (n_lines > 0);
    #(n_lines * 2000);
    stop_run("Timeout: the golden tests did not finish in time");
  end

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial begin
    int          fd;
    int          r;
    int          ch;
    int          lines;
    string       op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
    clk_i = 1'b0;
    rst_ni = 1'b0;
    req_i = '0;
    v_i = 1'b0;
    fence_t_i = 1'b0;
    pc_commit_i = '0;
    boot_addr_i = BootAddr;
    cache_busy_i = 1'b0;
    halt_csr_i = 1'b0;
    fence_t_pad_i = '0;
    fence_t_src_sel_i = 1'b0;
    time_irq_i = 1'b0;
    priv_lvl_i = PRIV_M;
    // Line count sets the watchdog budget
    fd = $fopen("verification/ctrl_golden.txt", "r");
    if (fd == 0) stop_run("Could not open the golden file");
    lines = 0;
    ch = $fgetc(fd);
    while (ch != -1) begin
      if (ch == 10) lines++;
      ch = $fgetc(fd);
    end
    $fclose(fd);
    n_lines = lines;
    repeat (8) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    fd = $fopen("verification/ctrl_golden.txt", "r");
    while (!$feof(fd)) begin
      r = $fscanf(fd, "%s", op);
      if (r != 1) break;
      if (op == "#") begin
        ch = $fgetc(fd);
        while (ch != 10 && ch != -1) ch = $fgetc(fd);
      end else if (op == "REQ") begin
        r = $fscanf(fd, "%h %h %h", a, b, c);
        do_req(a, b, c);
      end else if (op == "FENCE") begin
        r = $fscanf(fd, "%d %d", a, b);
        do_fence(a, b);
      end else if (op == "FENCE_T") begin
        r = $fscanf(fd, "%h %d %d %d", a, b, c, d);
        do_fence_t(a, b, c, d);
      end else if (op == "RESET_CHECK") begin
        apply_reset();
        check_reset_values();
        probe_wfi_halt();
      end else begin
        stop_run($sformatf("Unknown opcode %s in the golden file", op));
      end
    end
    $fclose(fd);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule
